// File: src/noc_pkg.sv
// Flit format and sizing for the message-passing adapter.
// One virtual channel only, so a flit carries no channel or class bits.
// Packets are 1 to NA_MAX_PKT flits long, the end is marked by last.
// Counter widths below follow NA_MAX_PKT and must be kept in step with it.

package noc_pkg;

   localparam int unsigned NOC_DATA_WIDTH = 32;   // Payload bits per flit
   localparam int unsigned NA_MAX_PKT     = 8;    // Longest packet in flits
   localparam int unsigned NA_FIFO_DEPTH  = 4;

   // Holds a flit count from 0 up to NA_MAX_PKT
   localparam int unsigned NA_CNT_WIDTH = $clog2(NA_MAX_PKT + 1);
   // Index into a packet store
   localparam int unsigned NA_IDX_WIDTH = $clog2(NA_MAX_PKT);

   typedef struct packed {
      logic [NOC_DATA_WIDTH-1:0] data;
      logic                      last;   // Final flit of a packet
   } noc_flit_t;

endpackage

// File: src/bus_pkg.sv
// Register bus seen by software on the compute tile.
// Word addressed, one access in flight, strobe held until ack.
// Only the three registers below exist; other addresses read as 0
// and ignore writes.
// Status bit 0 is the packet-ready flag, the rest reads 0.

package bus_pkg;

   localparam int unsigned BUS_ADDR_WIDTH = 4;
   localparam int unsigned BUS_DATA_WIDTH = 32;

   typedef enum logic [BUS_ADDR_WIDTH-1:0] {
      REG_SEND   = 4'd0,   // Size word, then payload words
      REG_RECV   = 4'd1,   // Size word, then flit data
      REG_STATUS = 4'd2
   } na_reg_e;

   typedef struct packed {
      logic                      stb;
      logic                      we;
      na_reg_e                   addr;
      logic [BUS_DATA_WIDTH-1:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic                      ack;   // One-cycle pulse
      logic [BUS_DATA_WIDTH-1:0] rdata;
   } bus_rsp_t;

endpackage

// File: src/noc_fifo.sv
`timescale 1ns/1ns
// Flit FIFO with valid/ready on both sides.
// No pass-through: a flit shows at the output one cycle after the push.
// Ready is low only when full; a full FIFO takes nothing even if it pops.
// DEPTH must be 2 or more.

module noc_fifo
   import noc_pkg::*;
#(
   parameter int unsigned DEPTH = NA_FIFO_DEPTH
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  noc_flit_t in_flit_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   output noc_flit_t out_flit_o,
   output logic      out_valid_o,
   input  logic      out_ready_i
);

   localparam int unsigned PTR_W = $clog2(DEPTH);
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   noc_flit_t        mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   assign in_ready_o  = (count_q != CNT_W'(DEPTH));
   assign out_valid_o = (count_q != '0);
   assign out_flit_o  = mem_q[rd_ptr_q];
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= in_flit_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Count and pointers agree at both ends, and the ends are respected
   a_full_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ((count_q == CNT_W'(DEPTH)) |-> (wr_ptr_q == rd_ptr_q) && !push) and
      ((count_q == '0) |-> (wr_ptr_q == rd_ptr_q) && !pop))
      else $error("FIFO push when full or pop when empty");

endmodule

// File: src/na_bus_decode.sv
`timescale 1ns/1ns
// Bus front end of the message-passing adapter.
// Ack and read data are registered, so any access takes at least two cycles.
// A send write is held towards the sender until it reports done.
// The master must drop or change stb in the cycle after ack.
// Reads of REG_SEND and writes to REG_RECV or REG_STATUS are acked and ignored.

module na_bus_decode
   import bus_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  bus_req_t                  bus_req_i,
   output bus_rsp_t                  bus_rsp_o,
   output logic                      send_wr_o,
   output logic [BUS_DATA_WIDTH-1:0] send_wdata_o,
   input  logic                      send_done_i,
   output logic                      recv_rd_o,
   input  logic [BUS_DATA_WIDTH-1:0] recv_rdata_i,
   input  logic                      recv_done_i,
   input  logic                      packet_ready_i
);

   logic                      ack_q;
   logic [BUS_DATA_WIDTH-1:0] rdata_q;
   logic                      live;
   logic                      ack_d;
   logic [BUS_DATA_WIDTH-1:0] rdata_d;

   // During the ack cycle stb is still the old access
   assign live         = bus_req_i.stb & ~ack_q;
   assign send_wdata_o = bus_req_i.wdata;

   always_comb begin
      send_wr_o = 1'b0;
      recv_rd_o = 1'b0;
      ack_d     = live;   // Default for registers answered locally
      rdata_d   = '0;
      case (bus_req_i.addr)
         REG_SEND: begin
            if (bus_req_i.we) begin
               send_wr_o = live;
               ack_d     = live & send_done_i;   // Sender may stall
            end
         end
         REG_RECV: begin
            if (!bus_req_i.we) begin
               recv_rd_o = live;
               ack_d     = live & recv_done_i;
               rdata_d   = recv_rdata_i;
            end
         end
         REG_STATUS: begin
            if (!bus_req_i.we) begin
               rdata_d = {{(BUS_DATA_WIDTH-1){1'b0}}, packet_ready_i};
            end
         end
         default: begin
            rdata_d = '0;   // Unknown address
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= ack_d;
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_q <= rdata_d;
   end

   assign bus_rsp_o.ack   = ack_q;
   assign bus_rsp_o.rdata = rdata_q;

   // Each access is answered by exactly one pulse
   a_ack_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_q |=> !ack_q)
      else $error("bus ack held for two cycles");

endmodule

// File: src/na_msg_send.sv
`timescale 1ns/1ns
// Packetizer for the send path.
// First write is the size word; 0 or more than NA_MAX_PKT is dropped.
// Each following write becomes one flit, the last one marked.
// A payload write is only consumed when the output register can take it,
// so done_o may come many cycles after wr_i rises.

module na_msg_send
   import noc_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      wr_i,
   input  logic [NOC_DATA_WIDTH-1:0] wdata_i,
   output logic                      done_o,
   output noc_flit_t                 flit_o,
   output logic                      valid_o,
   input  logic                      ready_i
);

   typedef enum logic {
      S_IDLE,
      S_PAYLOAD
   } send_state_e;

   send_state_e             state_q;
   logic [NA_CNT_WIDTH-1:0] remain_q;   // Payload words still expected
   noc_flit_t               flit_q;
   logic                    valid_q;
   logic                    size_ok;
   logic                    slot_free;
   logic                    take;

   assign size_ok   = (wdata_i != '0) && (wdata_i <= NA_MAX_PKT);
   assign slot_free = ~valid_q | ready_i;   // Output empty or emptying now
   assign take      = wr_i & ((state_q == S_IDLE) | slot_free);
   assign done_o    = take;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= S_IDLE;
         remain_q <= '0;
         valid_q  <= 1'b0;
      end else begin
         if (valid_q && ready_i) begin
            valid_q <= 1'b0;
         end
         if (take) begin
            case (state_q)
               S_IDLE: begin
                  if (size_ok) begin
                     state_q  <= S_PAYLOAD;
                     remain_q <= wdata_i[NA_CNT_WIDTH-1:0];
                  end
               end
               S_PAYLOAD: begin
                  valid_q  <= 1'b1;   // Overrides the clear above
                  remain_q <= remain_q - 1'b1;
                  if (remain_q == NA_CNT_WIDTH'(1)) begin
                     state_q <= S_IDLE;
                  end
               end
               default: state_q <= S_IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (take && state_q == S_PAYLOAD) begin
         flit_q.data <= wdata_i;
         flit_q.last <= (remain_q == NA_CNT_WIDTH'(1));
      end
   end

   assign flit_o  = flit_q;
   assign valid_o = valid_q;

   // Offered flit must not change before the FIFO takes it
   a_flit_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_o && !ready_i |=> valid_o && $stable(flit_o))
      else $error("send flit changed under back-pressure");

endmodule

// File: src/na_msg_recv.sv
`timescale 1ns/1ns
// Receive side: gathers one packet, then serves it to bus reads.
// While a packet is held no flits are taken, so the input FIFO backs up.
// First read gives the flit count, the following ones the flit data.
// Reads with no packet held return 0.
// Packets longer than NA_MAX_PKT flits are not supported.

module na_msg_recv
   import noc_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  noc_flit_t                 flit_i,
   input  logic                      valid_i,
   output logic                      ready_o,
   input  logic                      rd_i,
   output logic [NOC_DATA_WIDTH-1:0] rdata_o,
   output logic                      done_o,
   output logic                      packet_ready_o
);

   typedef enum logic [1:0] {
      S_COLLECT,
      S_HOLD_SIZE,
      S_HOLD_DATA
   } recv_state_e;

   recv_state_e               state_q;
   logic [NOC_DATA_WIDTH-1:0] store_q [NA_MAX_PKT];
   logic [NA_CNT_WIDTH-1:0]   count_q;
   logic [NA_IDX_WIDTH-1:0]   rd_idx_q;
   logic                      accept;
   logic                      last_rd;

   assign ready_o        = (state_q == S_COLLECT);
   assign accept         = valid_i & ready_o;
   assign packet_ready_o = (state_q != S_COLLECT);
   assign done_o         = rd_i;   // Reads always complete at once
   assign last_rd        = (NA_CNT_WIDTH'(rd_idx_q) + 1'b1 == count_q);

   always_comb begin
      case (state_q)
         S_HOLD_SIZE: rdata_o = NOC_DATA_WIDTH'(count_q);
         S_HOLD_DATA: rdata_o = store_q[rd_idx_q];
         default:     rdata_o = '0;   // Nothing held
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         store_q[count_q[NA_IDX_WIDTH-1:0]] <= flit_i.data;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= S_COLLECT;
         count_q  <= '0;
         rd_idx_q <= '0;
      end else begin
         case (state_q)
            S_COLLECT: begin
               if (accept) begin
                  count_q <= count_q + 1'b1;
                  if (flit_i.last) begin
                     state_q <= S_HOLD_SIZE;
                  end
               end
            end
            S_HOLD_SIZE: begin
               if (rd_i) begin
                  state_q  <= S_HOLD_DATA;
                  rd_idx_q <= '0;
               end
            end
            S_HOLD_DATA: begin
               if (rd_i) begin
                  rd_idx_q <= rd_idx_q + 1'b1;
                  if (last_rd) begin   // Packet drained, collect next
                     state_q <= S_COLLECT;
                     count_q <= '0;
                  end
               end
            end
            default: state_q <= S_COLLECT;
         endcase
      end
   end

   // Senders must mark last within NA_MAX_PKT flits
   a_pkt_len : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      count_q <= NA_CNT_WIDTH'(NA_MAX_PKT))
      else $error("incoming packet longer than NA_MAX_PKT");

endmodule

// File: src/networkadapter_mp.sv
`timescale 1ns/1ns
// Message-passing network adapter for a compute tile, one NoC link.
// Send: bus writes -> packetizer -> output FIFO -> link.
// Receive: link -> input FIFO -> packet store -> bus reads.
// irq_o is level, high while a received packet waits to be read.
// No DMA, no second virtual channel, no retry or error responses.

module networkadapter_mp
   import noc_pkg::*, bus_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  bus_req_t  bus_req_i,
   output bus_rsp_t  bus_rsp_o,
   output noc_flit_t noc_out_o,
   output logic      noc_out_valid_o,
   input  logic      noc_out_ready_i,
   input  noc_flit_t noc_in_i,
   input  logic      noc_in_valid_i,
   output logic      noc_in_ready_o,
   output logic      irq_o
);

   logic                      send_wr;
   logic [BUS_DATA_WIDTH-1:0] send_wdata;
   logic                      send_done;
   logic                      recv_rd;
   logic [BUS_DATA_WIDTH-1:0] recv_rdata;
   logic                      recv_done;
   logic                      packet_ready;
   noc_flit_t                 send_flit;     // Packetizer to output FIFO
   logic                      send_valid;
   logic                      send_ready;
   noc_flit_t                 recv_flit;     // Input FIFO to packet store
   logic                      recv_valid;
   logic                      recv_ready;

   na_bus_decode u_decode (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .bus_req_i      (bus_req_i),
      .bus_rsp_o      (bus_rsp_o),
      .send_wr_o      (send_wr),
      .send_wdata_o   (send_wdata),
      .send_done_i    (send_done),
      .recv_rd_o      (recv_rd),
      .recv_rdata_i   (recv_rdata),
      .recv_done_i    (recv_done),
      .packet_ready_i (packet_ready)
   );

   na_msg_send u_send (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wr_i    (send_wr),
      .wdata_i (send_wdata),
      .done_o  (send_done),
      .flit_o  (send_flit),
      .valid_o (send_valid),
      .ready_i (send_ready)
   );

   noc_fifo #(.DEPTH(NA_FIFO_DEPTH)) u_outfifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (send_flit),
      .in_valid_i  (send_valid),
      .in_ready_o  (send_ready),
      .out_flit_o  (noc_out_o),
      .out_valid_o (noc_out_valid_o),
      .out_ready_i (noc_out_ready_i)
   );

   noc_fifo #(.DEPTH(NA_FIFO_DEPTH)) u_infifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (noc_in_i),
      .in_valid_i  (noc_in_valid_i),
      .in_ready_o  (noc_in_ready_o),
      .out_flit_o  (recv_flit),
      .out_valid_o (recv_valid),
      .out_ready_i (recv_ready)
   );

   na_msg_recv u_recv (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .flit_i         (recv_flit),
      .valid_i        (recv_valid),
      .ready_o        (recv_ready),
      .rd_i           (recv_rd),
      .rdata_o        (recv_rdata),
      .done_o         (recv_done),
      .packet_ready_o (packet_ready)
   );

   assign irq_o = packet_ready;

endmodule

// File: tb/networkadapter_mp_tb.sv
`timescale 1ns/1ns
// Self-checking testbench for the message-passing network adapter.
// Send path is compared against a model of the size-word rule,
// receive path against the words driven onto the link.
// Inputs change on the falling edge, link outputs are taken on the rising edge.
// The run stops at the first mismatch.

module networkadapter_mp_tb
   import noc_pkg::*, bus_pkg::*;
();

   localparam int NUM_SEND_PKTS = 12;
   // Send packets, one bad-size case, and 18 flits driven on the link
   localparam int TOTAL_FLITS     = NUM_SEND_PKTS * NA_MAX_PKT + 3 + 18;
   localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 40 + 2000;

   typedef logic [31:0] word_q_t[$];
   typedef noc_flit_t flit_q_t[$];

   logic      clk;
   logic      rst_n;
   bus_req_t  bus_req;
   bus_rsp_t  bus_rsp;
   noc_flit_t noc_out;
   logic      noc_out_valid;
   logic      noc_out_ready;
   noc_flit_t noc_in;
   logic      noc_in_valid;
   logic      noc_in_ready;
   logic      irq;
   integer    seed;
   integer    bp_seed;      // Separate stream for link back-pressure
   logic      bp_on;
   logic      link_done;
   flit_q_t   exp_q;        // Flits still owed on the link output
   noc_flit_t exp_flit;

   networkadapter_mp dut0 (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .bus_req_i       (bus_req),
      .bus_rsp_o       (bus_rsp),
      .noc_out_o       (noc_out),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready),
      .noc_in_i        (noc_in),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .irq_o           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_run();
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] got);
      assert (exp_v === got) else begin
         $display("Error %s exp %h got %h", name, exp_v, got);
         stop_run();
      end
   endtask

   // Reference model of the send rule, whole write sequence in, flits out
   function automatic flit_q_t expected_flits(input word_q_t writes);
      flit_q_t   flits;
      int        remain;
      noc_flit_t f;
      remain = 0;
      foreach (writes[i]) begin
         if (remain == 0) begin
            if (writes[i] >= 1 && writes[i] <= NA_MAX_PKT) begin
               remain = int'(writes[i]);
            end
         end else begin
            f.data = writes[i];
            f.last = (remain == 1);
            flits.push_back(f);
            remain--;
         end
      end
      return flits;
   endfunction

   task automatic bus_access(input logic we, input na_reg_e addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      @(negedge clk);
      bus_req.stb   = 1'b1;
      bus_req.we    = we;
      bus_req.addr  = addr;
      bus_req.wdata = wdata;
      do @(negedge clk); while (!bus_rsp.ack);
      rdata       = bus_rsp.rdata;
      bus_req.stb = 1'b0;   // Ack cycle, master lets go
   endtask

   task automatic send_words(input word_q_t writes);
      flit_q_t     flits;
      logic [31:0] unused_rdata;
      flits = expected_flits(writes);
      foreach (flits[i]) exp_q.push_back(flits[i]);
      foreach (writes[i]) bus_access(1'b1, REG_SEND, writes[i], unused_rdata);
   endtask

   task automatic build_payload(input int len, output word_q_t words);
      words.delete();
      repeat (len) words.push_back($random(seed));
   endtask

   task automatic send_packet(input word_q_t payload);
      word_q_t writes;
      writes.push_back(32'(payload.size()));   // Size word first
      foreach (payload[i]) writes.push_back(payload[i]);
      send_words(writes);
   endtask

   task automatic drive_link(input word_q_t words);
      foreach (words[i]) begin
         @(negedge clk);
         noc_in.data  = words[i];
         noc_in.last  = (i == words.size() - 1);
         noc_in_valid = 1'b1;
         while (!noc_in_ready) @(negedge clk);   // Ready is stable here
      end
      @(negedge clk);
      noc_in_valid = 1'b0;
   endtask

   task automatic read_packet(input word_q_t words);
      logic [31:0] rdata;
      rdata = '0;
      while (!rdata[0]) bus_access(1'b0, REG_STATUS, '0, rdata);
      check_val("bus_rsp_o.rdata", 32'd1, rdata);   // Only the ready bit is set
      check_val("irq_o", 32'd1, 32'(irq));
      bus_access(1'b0, REG_RECV, '0, rdata);
      check_val("bus_rsp_o.rdata", 32'(words.size()), rdata);
      foreach (words[i]) begin
         bus_access(1'b0, REG_RECV, '0, rdata);
         check_val("bus_rsp_o.rdata", words[i], rdata);
      end
      check_val("irq_o", 32'd0, 32'(irq));   // Drained, collecting again
   endtask

   // Link back-pressure, about one cycle in four ready
   initial begin
      logic [31:0] rnd;
      @(posedge rst_n);
      forever begin
         @(negedge clk);
         rnd           = $random(bp_seed);
         noc_out_ready = bp_on ? (rnd[1:0] == 2'b00) : 1'b1;
      end
   end

   always @(posedge clk) begin
      if (rst_n && noc_out_valid && noc_out_ready) begin
         if (exp_q.size() == 0) begin
            $display("A flit left on the link output when none was expected");
            stop_run();
         end else begin
            exp_flit = exp_q.pop_front();
            check_val("noc_out_o.data", exp_flit.data, noc_out.data);
            check_val("noc_out_o.last", 32'(exp_flit.last), 32'(noc_out.last));
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timed out after %0d cycles without finishing the tests", WATCHDOG_CYCLES);
      stop_run();
   end

   initial begin
      word_q_t     words;
      word_q_t     pkt1;
      word_q_t     pkt2;
      word_q_t     pkt3;
      logic [31:0] rdata;
      int          len;
      seed          = 32'he5dd_8a6f;
      bp_seed       = ~seed;
      bp_on         = 1'b0;
      link_done     = 1'b0;
      rst_n         = 1'b0;
      bus_req       = '0;
      noc_in        = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      @(negedge clk);
      check_val("bus_rsp_o.ack", 32'd0, 32'(bus_rsp.ack));
      check_val("noc_out_valid_o", 32'd0, 32'(noc_out_valid));
      check_val("irq_o", 32'd0, 32'(irq));
      check_val("noc_in_ready_o", 32'd1, 32'(noc_in_ready));

      bp_on = 1'b1;
      repeat (NUM_SEND_PKTS) begin
         len = 1 + int'($unsigned($random(seed)) % NA_MAX_PKT);
         build_payload(len, words);
         send_packet(words);
      end

      // Sizes 0 and 9 are dropped, the next packet goes out as usual
      words.delete();
      words.push_back(32'd0);
      words.push_back(32'd9);
      send_words(words);
      build_payload(3, words);
      send_packet(words);
      while (exp_q.size() != 0) @(negedge clk);
      bp_on = 1'b0;

      build_payload(5, pkt1);
      drive_link(pkt1);
      read_packet(pkt1);

      bus_access(1'b0, REG_RECV, '0, rdata);
      check_val("bus_rsp_o.rdata", 32'd0, rdata);

      // Three packets back to back, the first one left unread for now
      build_payload(6, pkt1);
      build_payload(3, pkt2);
      build_payload(4, pkt3);
      fork
         begin
            drive_link(pkt1);
            drive_link(pkt2);
            drive_link(pkt3);
            link_done = 1'b1;
         end
      join_none
      while (noc_in_ready) @(negedge clk);

      // A packet is held now, so aliasing onto RECV or STATUS would show
      bus_access(1'b1, na_reg_e'(4'd9), 32'hffff_ffff, rdata);
      bus_access(1'b0, na_reg_e'(4'd9), '0, rdata);
      check_val("bus_rsp_o.rdata", 32'd0, rdata);
      bus_access(1'b0, na_reg_e'(4'd10), '0, rdata);
      check_val("bus_rsp_o.rdata", 32'd0, rdata);

      read_packet(pkt1);
      read_packet(pkt2);
      read_packet(pkt3);
      while (!link_done) @(negedge clk);

      repeat (20) @(negedge clk);
      if (exp_q.size() == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Some expected flits never left on the link output");
         stop_run();
      end
   end

endmodule

// File: networkadapter_mp.f
src/noc_pkg.sv
src/bus_pkg.sv
src/noc_fifo.sv
src/na_bus_decode.sv
src/na_msg_send.sv
src/na_msg_recv.sv
src/networkadapter_mp.sv
tb/networkadapter_mp_tb.sv

// File: Makefile
TOP := networkadapter_mp_tb

all: run

obj_dir/V$(TOP): networkadapter_mp.f $(wildcard src/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f networkadapter_mp.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
